//--- design/board_map_pkg.sv
/*
 * register map of the misc window, request struct, opcode and region enums
 */
package board_map_pkg;

  // register port geometry
  localparam int reg_dwidth         = 32;
  localparam int reg_awidth_default = 14;

  // misc window, 16 KiB at this base
  localparam logic [31:0] misc_base_default = 32'h4001_0000;

  //////////////////////////////////////////////////////////////////////
  // byte offsets inside the misc window
  //////////////////////////////////////////////////////////////////////
  localparam logic [reg_awidth_default-1:0] off_scratch  = 14'h0000;
  localparam logic [reg_awidth_default-1:0] off_clk_ctrl = 14'h0004;
  localparam logic [reg_awidth_default-1:0] off_sfp_ctrl = 14'h0008;
  localparam logic [reg_awidth_default-1:0] off_status   = 14'h000C;
  localparam logic [reg_awidth_default-1:0] off_led_ctrl = 14'h0010;

  // filler for reads that miss the window
  localparam logic [reg_dwidth-1:0] unmapped_read_value = 32'hDEAD_BEEF;

  // clk_ctrl: [2:0] mgt/mainref/ddr pwr, [4:3] cdcm/25m pwr, [5] resetn
  // [7:6] pr1/pr0, [10:8] od2/od1/od0
  // all on, dividers strapped for 125 MHz out (od2 low)
  localparam logic [reg_dwidth-1:0] clk_ctrl_reset = 32'h0000_03FF;

  // led_ctrl: [0] gps led, [2:1] sfp led a per port
  localparam logic [reg_dwidth-1:0] led_ctrl_reset = 32'h0000_0001;

  typedef enum logic {op_read, op_write} reg_op_e;

  typedef enum logic {region_misc, region_unmapped} reg_region_e;

  // one decoded register access, 53 bits
  typedef struct packed {
    logic                            valid;
    reg_op_e                         op;
    reg_region_e                     region;
    logic [reg_awidth_default-1:0]   offset;
    logic [reg_dwidth-1:0]           data;
    logic [reg_dwidth/8-1:0]         keep;
  } reg_req_t;

endpackage

//--- design/board_io_pkg.sv
/*
 * board pin groups: clock power enables, cdcm straps, sfp+ control
 */
package board_io_pkg;

  // two sfp+ cages on the carrier
  localparam int sfp_ports = 2;

  // clock tree power enables
  typedef struct packed {
    logic mgt156;
    logic mainref;
    logic ddr100;
    logic wb_cdcm;
    logic wb_25mhz;
  } pwr_en_t;

  // cdcm synthesizer strap pins
  // pr1/pr0 prescaler+feedback, od2..od0 output divider
  typedef struct packed {
    logic resetn;
    logic pr1;
    logic pr0;
    logic od2;
    logic od1;
    logic od0;
  } cdcm_cfg_t;

  // per cage low speed control
  typedef struct packed {
    logic tx_disable;
    logic rs0;
    logic rs1;
  } sfp_ctrl_t;

endpackage

//--- design/reg_port_decode.sv
/*
 * register port front end: strobe select, window decode, request register
 */
`timescale 1ns/1ps

module reg_port_decode #(
  parameter logic [31:0] misc_base  = board_map_pkg::misc_base_default,
  parameter int          reg_awidth = board_map_pkg::reg_awidth_default
) (
  input  logic                                   FCLK_CLK0,
  input  logic                                   FCLK_RESET0,
  input  logic                                   reg_wr_req,
  input  logic [31:0]                            reg_wr_addr,
  input  logic [board_map_pkg::reg_dwidth-1:0]   reg_wr_data,
  input  logic [board_map_pkg::reg_dwidth/8-1:0] reg_wr_keep,
  input  logic                                   reg_rd_req,
  input  logic [31:0]                            reg_rd_addr,
  output board_map_pkg::reg_req_t                req
);

  import board_map_pkg::*;

  reg_op_e     op_sel;
  logic [31:0] addr_sel;
  reg_req_t    req_d;

  // write wins, a read in the same cycle is dropped
  always_comb begin
    if (reg_wr_req) begin
      op_sel   = op_write;
      addr_sel = reg_wr_addr;
    end else begin
      op_sel   = op_read;
      addr_sel = reg_rd_addr;
    end
  end

  // upper bits against the window base
  always_comb begin
    req_d        = '0;
    req_d.valid  = reg_wr_req | reg_rd_req;
    req_d.op     = op_sel;
    if (addr_sel[31:reg_awidth] == misc_base[31:reg_awidth])
      req_d.region = region_misc;
    else
      req_d.region = region_unmapped;
    req_d.offset = reg_awidth_default'(addr_sel[reg_awidth-1:0]);
    // only meaningful on writes
    req_d.data   = reg_wr_data;
    req_d.keep   = reg_wr_keep;
  end

  // request register, empty after reset
  always_ff @(posedge FCLK_CLK0) begin
    if (FCLK_RESET0)
      req <= '0;
    else
      req <= req_d;
  end

endmodule

//--- design/board_ctrl_regs.sv
/*
 * misc register file: scratch, clock control, sfp control, led control
 * link status sampling and read response
 */
`timescale 1ns/1ps

module board_ctrl_regs (
  input  logic                                    FCLK_CLK0,
  input  logic                                    FCLK_RESET0,
  input  board_map_pkg::reg_req_t                 req,
  input  logic [1:0]                              phy_link,
  output logic                                    reg_rd_resp,
  output logic [board_map_pkg::reg_dwidth-1:0]    reg_rd_data,
  output board_io_pkg::pwr_en_t                   pwr_en,
  output board_io_pkg::cdcm_cfg_t                 cdcm_cfg,
  output board_io_pkg::sfp_ctrl_t [board_io_pkg::sfp_ports-1:0] sfp_ctrl,
  output logic [2:0]                              led_ctrl
);

  import board_map_pkg::*;
  import board_io_pkg::*;

  logic [reg_dwidth-1:0] scratch_q;
  logic [reg_dwidth-1:0] clk_ctrl_q;
  logic [reg_dwidth-1:0] sfp_ctrl_q;
  logic [reg_dwidth-1:0] led_ctrl_q;
  logic [reg_dwidth-1:0] status_q;
  logic [reg_dwidth-1:0] rd_word;
  logic                  wr_misc;
  logic                  rd_hit;

  // merge new data into old word, byte lanes under keep
  function automatic logic [reg_dwidth-1:0] apply_keep(
    input logic [reg_dwidth-1:0]   old_word,
    input logic [reg_dwidth-1:0]   new_word,
    input logic [reg_dwidth/8-1:0] keep
  );
    logic [reg_dwidth-1:0] merged;
    merged = old_word;
    for (int b = 0; b < reg_dwidth/8; b++) begin
      if (keep[b])
        merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

  assign wr_misc = req.valid && (req.op == op_write) && (req.region == region_misc);
  assign rd_hit  = req.valid && (req.op == op_read);

  //////////////////////////////////////////////////////////////////////
  // writable registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge FCLK_CLK0) begin
    if (FCLK_RESET0) begin
      scratch_q  <= '0;
      clk_ctrl_q <= clk_ctrl_reset;
      sfp_ctrl_q <= '0;
      led_ctrl_q <= led_ctrl_reset;
    end else if (wr_misc) begin
      // status and unknown offsets fall through untouched
      case (req.offset)
        off_scratch:  scratch_q  <= apply_keep(scratch_q, req.data, req.keep);
        off_clk_ctrl: clk_ctrl_q <= apply_keep(clk_ctrl_q, req.data, req.keep);
        off_sfp_ctrl: sfp_ctrl_q <= apply_keep(sfp_ctrl_q, req.data, req.keep);
        off_led_ctrl: led_ctrl_q <= apply_keep(led_ctrl_q, req.data, req.keep);
        default: ;
      endcase
    end
  end

  // link status, resampled every cycle
  always_ff @(posedge FCLK_CLK0) begin
    if (FCLK_RESET0)
      status_q <= '0;
    else
      status_q <= {{(reg_dwidth-2){1'b0}}, phy_link};
  end

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    if (req.region == region_unmapped) begin
      rd_word = unmapped_read_value;
    end else begin
      case (req.offset)
        off_scratch:  rd_word = scratch_q;
        off_clk_ctrl: rd_word = clk_ctrl_q;
        off_sfp_ctrl: rd_word = sfp_ctrl_q;
        off_status:   rd_word = status_q;
        off_led_ctrl: rd_word = led_ctrl_q;
        // holes in the window read as zero
        default:      rd_word = '0;
      endcase
    end
  end

  always_ff @(posedge FCLK_CLK0) begin
    if (FCLK_RESET0)
      reg_rd_resp <= 1'b0;
    else
      reg_rd_resp <= rd_hit;
  end

  always_ff @(posedge FCLK_CLK0) begin
    reg_rd_data <= rd_word;
  end

  //////////////////////////////////////////////////////////////////////
  // pin fan out
  //////////////////////////////////////////////////////////////////////
  assign pwr_en.mgt156   = clk_ctrl_q[2];
  assign pwr_en.mainref  = clk_ctrl_q[1];
  assign pwr_en.ddr100   = clk_ctrl_q[0];
  assign pwr_en.wb_cdcm  = clk_ctrl_q[4];
  assign pwr_en.wb_25mhz = clk_ctrl_q[3];

  // resetn, pr1, pr0, od2, od1, od0
  assign cdcm_cfg = {clk_ctrl_q[5], clk_ctrl_q[7:6], clk_ctrl_q[10:8]};

  // port 0 in [2:0], port 1 in [5:3]
  assign sfp_ctrl = sfp_ctrl_q[3*sfp_ports-1:0];

  assign led_ctrl = led_ctrl_q[2:0];

endmodule

//--- design/panel_led_driver.sv
/*
 * heartbeat counter, panel and sfp led drive
 */
`timescale 1ns/1ps

module panel_led_driver #(
  parameter int heartbeat_bit = 26
) (
  input  logic       FCLK_CLK0,
  input  logic       FCLK_RESET0,
  input  logic [1:0] phy_link,
  input  logic [2:0] led_ctrl,
  output logic       panel_led_link,
  output logic       panel_led_gps,
  output logic [1:0] sfp_led_a,
  output logic [1:0] sfp_led_b
);

  logic [31:0] hb_cnt;

  // free running, wraps
  always_ff @(posedge FCLK_CLK0) begin
    if (FCLK_RESET0)
      hb_cnt <= 32'd0;
    else
      hb_cnt <= hb_cnt + 32'd1;
  end

  // blink period 2^(heartbeat_bit+1) cycles
  assign panel_led_link = hb_cnt[heartbeat_bit];

  // software driven leds
  assign panel_led_gps = led_ctrl[0];
  assign sfp_led_a     = led_ctrl[2:1];

  // link leds straight from phy status
  assign sfp_led_b = phy_link;

endmodule

//--- design/board_ctrl_top.sv
/*
 * board control top: register decode, register file, led driver
 */
`timescale 1ns/1ps

module board_ctrl_top #(
  parameter logic [31:0] misc_base     = board_map_pkg::misc_base_default,
  parameter int          reg_awidth    = board_map_pkg::reg_awidth_default,
  parameter int          heartbeat_bit = 26
) (
  input  logic                                    FCLK_CLK0,
  input  logic                                    FCLK_RESET0,
  // register port
  input  logic                                    reg_wr_req,
  input  logic [31:0]                             reg_wr_addr,
  input  logic [board_map_pkg::reg_dwidth-1:0]    reg_wr_data,
  input  logic [board_map_pkg::reg_dwidth/8-1:0]  reg_wr_keep,
  input  logic                                    reg_rd_req,
  input  logic [31:0]                             reg_rd_addr,
  output logic                                    reg_rd_resp,
  output logic [board_map_pkg::reg_dwidth-1:0]    reg_rd_data,
  // board pins
  input  logic [1:0]                              phy_link,
  output board_io_pkg::pwr_en_t                   pwr_en,
  output board_io_pkg::cdcm_cfg_t                 cdcm_cfg,
  output board_io_pkg::sfp_ctrl_t [board_io_pkg::sfp_ports-1:0] sfp_ctrl,
  output logic                                    panel_led_link,
  output logic                                    panel_led_gps,
  output logic [1:0]                              sfp_led_a,
  output logic [1:0]                              sfp_led_b
);

  import board_map_pkg::*;

  reg_req_t   req;
  logic [2:0] led_ctrl;

  //////////////////////////////////////////////////////////////////////
  // register access path
  //////////////////////////////////////////////////////////////////////
  reg_port_decode #(
    .misc_base  (misc_base),
    .reg_awidth (reg_awidth)
  ) u_decode (
    .FCLK_CLK0   (FCLK_CLK0),
    .FCLK_RESET0 (FCLK_RESET0),
    .reg_wr_req  (reg_wr_req),
    .reg_wr_addr (reg_wr_addr),
    .reg_wr_data (reg_wr_data),
    .reg_wr_keep (reg_wr_keep),
    .reg_rd_req  (reg_rd_req),
    .reg_rd_addr (reg_rd_addr),
    .req         (req)
  );

  board_ctrl_regs u_regs (
    .FCLK_CLK0   (FCLK_CLK0),
    .FCLK_RESET0 (FCLK_RESET0),
    .req         (req),
    .phy_link    (phy_link),
    .reg_rd_resp (reg_rd_resp),
    .reg_rd_data (reg_rd_data),
    .pwr_en      (pwr_en),
    .cdcm_cfg    (cdcm_cfg),
    .sfp_ctrl    (sfp_ctrl),
    .led_ctrl    (led_ctrl)
  );

  // front panel and cage leds
  panel_led_driver #(
    .heartbeat_bit (heartbeat_bit)
  ) u_leds (
    .FCLK_CLK0      (FCLK_CLK0),
    .FCLK_RESET0    (FCLK_RESET0),
    .phy_link       (phy_link),
    .led_ctrl       (led_ctrl),
    .panel_led_link (panel_led_link),
    .panel_led_gps  (panel_led_gps),
    .sfp_led_a      (sfp_led_a),
    .sfp_led_b      (sfp_led_b)
  );

endmodule

//--- tests/board_ctrl_tb.sv
/*
 * testbench for board_ctrl_top: register table, back-to-back reads,
 * link status and heartbeat
 */
`timescale 1ns/1ps

module board_ctrl_tb;

  import board_map_pkg::*;
  import board_io_pkg::*;

  localparam int          hb_bit       = 3;
  localparam logic [31:0] win_base     = 32'h4001_0000;
  localparam int          resp_timeout = 20;
  // all clock enables and straps on, od2 (bit 10) low
  localparam logic [31:0] clk_rst      = 32'h0000_03FF;

  // pin group compared by a table step
  localparam logic [2:0] pin_none = 3'd0;
  localparam logic [2:0] pin_pwr  = 3'd1;
  localparam logic [2:0] pin_cdcm = 3'd2;
  localparam logic [2:0] pin_sfp  = 3'd3;
  localparam logic [2:0] pin_led  = 3'd4;

  typedef struct packed {
    reg_op_e     op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  keep;
    logic [31:0] exp_rd;
    logic [2:0]  pin_sel;
    logic [31:0] exp_pin;
  } step_t;

  logic        FCLK_CLK0;
  logic        FCLK_RESET0;
  logic        reg_wr_req;
  logic [31:0] reg_wr_addr;
  logic [31:0] reg_wr_data;
  logic [3:0]  reg_wr_keep;
  logic        reg_rd_req;
  logic [31:0] reg_rd_addr;
  logic        reg_rd_resp;
  logic [31:0] reg_rd_data;
  logic [1:0]  phy_link;
  pwr_en_t     pwr_en;
  cdcm_cfg_t   cdcm_cfg;
  sfp_ctrl_t [sfp_ports-1:0] sfp_ctrl;
  logic        panel_led_link;
  logic        panel_led_gps;
  logic [1:0]  sfp_led_a;
  logic [1:0]  sfp_led_b;

  step_t       steps[$];
  integer      seed;
  logic [31:0] rand_word;
  logic [31:0] part_word;
  logic [31:0] rd0;
  logic [31:0] rd1;

  board_ctrl_top #(
    .misc_base     (win_base),
    .reg_awidth    (14),
    .heartbeat_bit (hb_bit)
  ) uut (
    .FCLK_CLK0      (FCLK_CLK0),
    .FCLK_RESET0    (FCLK_RESET0),
    .reg_wr_req     (reg_wr_req),
    .reg_wr_addr    (reg_wr_addr),
    .reg_wr_data    (reg_wr_data),
    .reg_wr_keep    (reg_wr_keep),
    .reg_rd_req     (reg_rd_req),
    .reg_rd_addr    (reg_rd_addr),
    .reg_rd_resp    (reg_rd_resp),
    .reg_rd_data    (reg_rd_data),
    .phy_link       (phy_link),
    .pwr_en         (pwr_en),
    .cdcm_cfg       (cdcm_cfg),
    .sfp_ctrl       (sfp_ctrl),
    .panel_led_link (panel_led_link),
    .panel_led_gps  (panel_led_gps),
    .sfp_led_a      (sfp_led_a),
    .sfp_led_b      (sfp_led_b)
  );

  // 8 ns period
  initial begin
    FCLK_CLK0 = 1'b0;
    forever #4 FCLK_CLK0 = ~FCLK_CLK0;
  end

  //////////////////////////////////////////////////////////////////////
  // expected pins from the clock control layout
  //////////////////////////////////////////////////////////////////////
  // mgt [2], mainref [1], ddr [0], synth [4], 25 MHz [3]
  function automatic logic [31:0] pwr_expect(input logic [31:0] w);
    return {27'd0, w[2], w[1], w[0], w[4], w[3]};
  endfunction

  // resetn [5], pr1 [7], pr0 [6], od2..od0 [10:8]
  function automatic logic [31:0] cdcm_expect(input logic [31:0] w);
    return {26'd0, w[5], w[7], w[6], w[10], w[9], w[8]};
  endfunction

  function automatic logic [31:0] pin_value(input logic [2:0] sel);
    case (sel)
      pin_pwr:  return {27'd0, pwr_en};
      pin_cdcm: return {26'd0, cdcm_cfg};
      pin_sfp:  return {26'd0, sfp_ctrl};
      pin_led:  return {29'd0, sfp_led_a, panel_led_gps};
      default:  return 32'd0;
    endcase
  endfunction

  function automatic string pin_name(input logic [2:0] sel);
    case (sel)
      pin_pwr:  return "pwr_en";
      pin_cdcm: return "cdcm_cfg";
      pin_sfp:  return "sfp_ctrl";
      default:  return "led pins";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic report_no_response(input logic [31:0] addr);
    $display("no read response for address 0x%h within %0d cycles", addr, resp_timeout);
    $display("*** TEST FAILED ***");
    $fatal(1, "read response timeout");
  endtask

  //////////////////////////////////////////////////////////////////////
  // register port access
  //////////////////////////////////////////////////////////////////////
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] keep);
    @(posedge FCLK_CLK0);
    reg_wr_req  <= 1'b1;
    reg_wr_addr <= addr;
    reg_wr_data <= data;
    reg_wr_keep <= keep;
    @(posedge FCLK_CLK0);
    reg_wr_req  <= 1'b0;
  endtask

  // one strobe, response expected 2 cycles later
  task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
    int waited;
    int got;
    waited = 0;
    got    = 0;
    data   = '0;
    @(posedge FCLK_CLK0);
    reg_rd_req  <= 1'b1;
    reg_rd_addr <= addr;
    while (!got && waited < resp_timeout) begin
      @(negedge FCLK_CLK0);
      if (reg_rd_resp === 1'b1) begin
        data = reg_rd_data;
        got  = 1;
      end else begin
        @(posedge FCLK_CLK0);
        waited++;
        if (waited == 1)
          reg_rd_req <= 1'b0;
      end
    end
    if (!got)
      report_no_response(addr);
    else
      check_value("read latency", waited, 2);
  endtask

  // two strobes in consecutive cycles, both in flight
  task automatic read_pair(input logic [31:0] a0, input logic [31:0] a1,
                           output logic [31:0] d0, output logic [31:0] d1);
    int waited;
    int got;
    int first_at;
    int second_at;
    waited    = 0;
    got       = 0;
    first_at  = -1;
    second_at = -1;
    d0        = '0;
    d1        = '0;
    @(posedge FCLK_CLK0);
    reg_rd_req  <= 1'b1;
    reg_rd_addr <= a0;
    while (got < 2 && waited < resp_timeout) begin
      @(negedge FCLK_CLK0);
      if (reg_rd_resp === 1'b1) begin
        if (got == 0) begin
          d0       = reg_rd_data;
          first_at = waited;
        end else begin
          d1        = reg_rd_data;
          second_at = waited;
        end
        got++;
      end
      @(posedge FCLK_CLK0);
      waited++;
      if (waited == 1)
        reg_rd_addr <= a1;
      else if (waited == 2)
        reg_rd_req <= 1'b0;
    end
    if (got < 2) begin
      report_no_response(a1);
    end else begin
      check_value("first read latency", first_at, 2);
      check_value("second read latency", second_at, 3);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////
  function automatic void add_step(input reg_op_e op, input logic [31:0] addr,
                                   input logic [31:0] data, input logic [3:0] keep,
                                   input logic [31:0] exp_rd, input logic [2:0] sel,
                                   input logic [31:0] exp_pin);
    steps.push_back('{op, addr, data, keep, exp_rd, sel, exp_pin});
  endfunction

  function automatic void build_table();
    // reset values and pins
    add_step(op_read, win_base, 0, 0, 32'h0, pin_pwr, pwr_expect(clk_rst));
    add_step(op_read, win_base + 32'h04, 0, 0, clk_rst, pin_cdcm, cdcm_expect(clk_rst));
    add_step(op_read, win_base + 32'h08, 0, 0, 32'h0, pin_sfp, 32'h0);
    add_step(op_read, win_base + 32'h0C, 0, 0, 32'h0, pin_none, 0);
    add_step(op_read, win_base + 32'h10, 0, 0, 32'h1, pin_led, 32'h1);
    // scratch, full word then bytes 0 and 2 only
    add_step(op_write, win_base, rand_word, 4'hF, 0, pin_none, 0);
    add_step(op_read, win_base, 0, 0, rand_word, pin_none, 0);
    add_step(op_write, win_base, 32'hA5A5_A5A5, 4'b0101, 0, pin_none, 0);
    add_step(op_read, win_base, 0, 0, part_word, pin_none, 0);
    // clock and sfp control onto the pins
    add_step(op_write, win_base + 32'h04, 32'h155, 4'hF, 0, pin_pwr, pwr_expect(32'h155));
    add_step(op_write, win_base + 32'h04, 32'h4AA, 4'h3, 0, pin_cdcm, cdcm_expect(32'h4AA));
    add_step(op_read, win_base + 32'h04, 0, 0, 32'h4AA, pin_pwr, pwr_expect(32'h4AA));
    add_step(op_write, win_base + 32'h08, 32'hFFFF_FF2E, 4'h1, 0, pin_sfp, 32'h2E);
    add_step(op_read, win_base + 32'h08, 0, 0, 32'h2E, pin_sfp, 32'h2E);
    // status word is read only
    add_step(op_write, win_base + 32'h0C, 32'hFFFF_FFFF, 4'hF, 0, pin_none, 0);
    add_step(op_read, win_base + 32'h0C, 0, 0, 32'h0, pin_none, 0);
    // misses the window, filler on reads, writes dropped
    add_step(op_read, 32'h4002_0000, 0, 0, 32'hDEAD_BEEF, pin_none, 0);
    add_step(op_read, 32'h0000_0000, 0, 0, 32'hDEAD_BEEF, pin_none, 0);
    add_step(op_write, 32'h4002_0000, 32'h1234_5678, 4'hF, 0, pin_none, 0);
    add_step(op_read, win_base, 0, 0, part_word, pin_none, 0);
    // holes inside the window
    add_step(op_read, win_base + 32'h20, 0, 0, 32'h0, pin_none, 0);
    add_step(op_read, win_base + 32'h3FFC, 0, 0, 32'h0, pin_none, 0);
    // led control, gps off, both led a on
    add_step(op_write, win_base + 32'h10, 32'h6, 4'hF, 0, pin_led, 32'h6);
    add_step(op_read, win_base + 32'h10, 0, 0, 32'h6, pin_led, 32'h6);
  endfunction

  task automatic apply_step(input step_t s);
    logic [31:0] old_pin;
    logic [31:0] rdata;
    @(negedge FCLK_CLK0);
    if (s.op == op_write) begin
      old_pin = pin_value(s.pin_sel);
      write_word(s.addr, s.data, s.keep);
      if (s.pin_sel != pin_none) begin
        // old value one cycle after the strobe, new value after two
        @(negedge FCLK_CLK0);
        check_value(pin_name(s.pin_sel), pin_value(s.pin_sel), old_pin);
        @(negedge FCLK_CLK0);
        check_value(pin_name(s.pin_sel), pin_value(s.pin_sel), s.exp_pin);
      end
    end else begin
      read_word(s.addr, rdata);
      check_value("reg_rd_data", rdata, s.exp_rd);
      if (s.pin_sel != pin_none)
        check_value(pin_name(s.pin_sel), pin_value(s.pin_sel), s.exp_pin);
    end
  endtask

  // counter starts at zero on the release edge, led follows its bit hb_bit
  task automatic check_heartbeat();
    logic exp_led;
    for (int i = 0; i < 4 * 2 * (1 << hb_bit); i++) begin
      @(negedge FCLK_CLK0);
      if (i == 0)
        check_value("reg_rd_resp", {31'd0, reg_rd_resp}, 32'd0);
      exp_led = ((i >> hb_bit) & 1) != 0;
      check_value("panel_led_link", {31'd0, panel_led_link}, {31'd0, exp_led});
    end
  endtask

  initial begin
    FCLK_RESET0 = 1'b1;
    reg_wr_req  = 1'b0;
    reg_wr_addr = '0;
    reg_wr_data = '0;
    reg_wr_keep = '0;
    reg_rd_req  = 1'b0;
    reg_rd_addr = '0;
    phy_link    = 2'b00;
    seed        = 32'h18ccfe44;
    rand_word   = $random(seed);
    part_word   = {rand_word[31:24], 8'hA5, rand_word[15:8], 8'hA5};
    build_table();

    repeat (5) @(posedge FCLK_CLK0);
    FCLK_RESET0 <= 1'b0;
    check_heartbeat();

    foreach (steps[i])
      apply_step(steps[i]);

    // scratch then led control, strobes one cycle apart
    read_pair(win_base, win_base + 32'h10, rd0, rd1);
    check_value("first read data", rd0, part_word);
    check_value("second read data", rd1, 32'h6);

    // link status word and cage leds
    for (int i = 1; i <= 4; i++) begin
      @(posedge FCLK_CLK0);
      phy_link <= 2'(i);
      @(negedge FCLK_CLK0);
      check_value("sfp_led_b", {30'd0, sfp_led_b}, 32'(i % 4));
      read_word(win_base + 32'h0C, rd0);
      check_value("status", rd0, 32'(i % 4));
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- sim.f
design/board_map_pkg.sv
design/board_io_pkg.sv
design/reg_port_decode.sv
design/board_ctrl_regs.sv
design/panel_led_driver.sv
design/board_ctrl_top.sv
tests/board_ctrl_tb.sv

//--- Bender.yml
package:
  name: board_ctrl

sources:
  # packages first, then the RTL bottom up
  - files:
      - design/board_map_pkg.sv
      - design/board_io_pkg.sv
      - design/reg_port_decode.sv
      - design/board_ctrl_regs.sv
      - design/panel_led_driver.sv
      - design/board_ctrl_top.sv
  - target: test
    files:
      - tests/board_ctrl_tb.sv
